//--- hdl/player_config.svh
`ifndef PLAYER_CONFIG_SVH
`define PLAYER_CONFIG_SVH

// ======================================================================
// Sample rate divider
// ======================================================================

// Reset divider gives roughly a 14.4 kHz sample tick at 50 MHz
`define DEFAULT_SAMPLE_DIV  16'd3472
`define SPEED_STEP          16'd100
`define MIN_SAMPLE_DIV      16'd1000
`define MAX_SAMPLE_DIV      16'd8000

// ======================================================================
// Song range in flash, word addresses
// ======================================================================

`define SONG_FIRST_WORD     23'h000000
`define SONG_LAST_WORD      23'h07FFFF

// Upper case ASCII key codes
`define KEY_PLAY            8'h45
`define KEY_STOP            8'h44
`define KEY_FORWARD         8'h46
`define KEY_BACKWARD        8'h42
`define KEY_RESTART         8'h52

`endif

//--- hdl/player_pkg.sv
`default_nettype none

package player_pkg;

  // One-cycle command events from the keyboard decoder
  typedef struct packed {
    logic play;
    logic stop;
    logic forward;
    logic backward;
    logic restart;
  } play_cmd_t;

  // Signed audio sample
  typedef logic signed [7:0] sample_t;

  // Sample tick divider in clock cycles
  typedef logic [15:0] divider_t;

  // Active-low segments with bit 0 as segment a
  typedef logic [6:0] seg_t;

  // Six digits with index 0 the least significant
  typedef seg_t [5:0] hex_digits_t;

endpackage

`default_nettype wire

//--- hdl/flash_bus_pkg.sv
`default_nettype none

package flash_bus_pkg;

  typedef logic [22:0] word_addr_t;
  typedef logic [31:0] flash_word_t;

  // AXI4-Lite read address channel from master to slave
  typedef struct packed {
    logic        arvalid;
    logic [24:0] araddr;
    logic [2:0]  arprot;
  } axil_ar_t;

  // AXI4-Lite read data channel from slave to master
  typedef struct packed {
    logic        rvalid;
    flash_word_t rdata;
    logic [1:0]  rresp;
  } axil_r_t;

endpackage

`default_nettype wire

//--- hdl/command_decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "player_config.svh"

module command_decoder (
  input  wire logic                CLK_50M,
  input  wire logic                rst_n,
  input  wire logic                key_valid,
  input  wire logic [7:0]          key_ascii,
  output player_pkg::play_cmd_t    cmd
);

  logic [7:0] key_upper;

  // Fold lower case letters onto upper case
  always_comb
  begin
    key_upper = key_ascii;
    if (key_ascii >= 8'h61 && key_ascii <= 8'h7A)
    begin
      key_upper = key_ascii - 8'h20;
    end
  end

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cmd <= '0;
    end
    else
    begin
      cmd <= '0;
      if (key_valid)
      begin
        case (key_upper)
          `KEY_PLAY:     cmd.play     <= 1'b1;
          `KEY_STOP:     cmd.stop     <= 1'b1;
          `KEY_FORWARD:  cmd.forward  <= 1'b1;
          `KEY_BACKWARD: cmd.backward <= 1'b1;
          `KEY_RESTART:  cmd.restart  <= 1'b1;
          default:       cmd          <= '0;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/rate_control.sv
`timescale 1ns/1ps
`default_nettype none
`include "player_config.svh"

module rate_control (
  input  wire logic               CLK_50M,
  input  wire logic               rst_n,
  input  wire logic               speed_up,
  input  wire logic               speed_down,
  input  wire logic               speed_reset,
  output player_pkg::divider_t    divider,
  output logic                    tick
);

  logic [2:0]           btn_q;
  logic                 up_pulse;
  logic                 down_pulse;
  logic                 reset_pulse;
  player_pkg::divider_t div_next;
  player_pkg::divider_t tick_cnt;

  // One registered pulse per button press
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      btn_q       <= '0;
      up_pulse    <= 1'b0;
      down_pulse  <= 1'b0;
      reset_pulse <= 1'b0;
    end
    else
    begin
      btn_q       <= {speed_reset, speed_down, speed_up};
      up_pulse    <= speed_up & ~btn_q[0];
      down_pulse  <= speed_down & ~btn_q[1];
      reset_pulse <= speed_reset & ~btn_q[2];
    end
  end

  // Faster playback means a smaller divider
  always_comb
  begin
    div_next = divider;
    if (reset_pulse)
      div_next = `DEFAULT_SAMPLE_DIV;
    else if (up_pulse)
      div_next = (divider < `MIN_SAMPLE_DIV + `SPEED_STEP) ?
                 `MIN_SAMPLE_DIV : divider - `SPEED_STEP;
    else if (down_pulse)
      div_next = (divider > `MAX_SAMPLE_DIV - `SPEED_STEP) ?
                 `MAX_SAMPLE_DIV : divider + `SPEED_STEP;
  end

  // ====================================================================
  // Divider register and sample tick counter
  // ====================================================================

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      divider  <= `DEFAULT_SAMPLE_DIV;
      tick_cnt <= `DEFAULT_SAMPLE_DIV;
      tick     <= 1'b0;
    end
    else
    begin
      divider <= div_next;
      if (div_next != divider)
      begin
        // New rate starts a fresh period
        tick_cnt <= div_next;
        tick     <= 1'b0;
      end
      else if (tick_cnt == '0)
      begin
        tick_cnt <= divider;
        tick     <= 1'b1;
      end
      else
      begin
        tick_cnt <= tick_cnt - 1'b1;
        tick     <= 1'b0;
      end
    end
  end

  a_divider_range: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    divider >= `MIN_SAMPLE_DIV && divider <= `MAX_SAMPLE_DIV);

endmodule

`default_nettype wire

//--- hdl/flash_reader.sv
`timescale 1ns/1ps
`default_nettype none

module flash_reader (
  input  wire logic                       CLK_50M,
  input  wire logic                       rst_n,
  input  wire logic                       fetch_req,
  input  wire flash_bus_pkg::word_addr_t  fetch_addr,
  output logic                            word_valid,
  output flash_bus_pkg::flash_word_t      word_data,
  output flash_bus_pkg::axil_ar_t         flash_ar,
  input  wire logic                       flash_arready,
  input  wire flash_bus_pkg::axil_r_t     flash_r,
  output logic                            flash_rready
);

  typedef enum logic [1:0] {S_IDLE, S_ADDR, S_DATA} state_t;

  state_t      state;
  logic        ar_valid;
  logic [24:0] ar_addr;

  always_comb
  begin
    flash_ar.arvalid = ar_valid;
    flash_ar.araddr  = ar_addr;
    flash_ar.arprot  = 3'b000;
  end

  // One read per request with a single transfer outstanding
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state        <= S_IDLE;
      ar_valid     <= 1'b0;
      flash_rready <= 1'b0;
      word_valid   <= 1'b0;
    end
    else
    begin
      word_valid <= 1'b0;
      case (state)
        S_IDLE:
        begin
          if (fetch_req)
          begin
            ar_valid <= 1'b1;
            state    <= S_ADDR;
          end
        end
        S_ADDR:
        begin
          if (flash_arready)
          begin
            ar_valid     <= 1'b0;
            flash_rready <= 1'b1;
            state        <= S_DATA;
          end
        end
        S_DATA:
        begin
          if (flash_r.rvalid)
          begin
            flash_rready <= 1'b0;
            word_valid   <= 1'b1;
            state        <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Address and returned word
  always_ff @(posedge CLK_50M)
  begin
    if (state == S_IDLE && fetch_req)
      ar_addr <= {fetch_addr, 2'b00};
    if (state == S_DATA && flash_r.rvalid)
      word_data <= flash_r.rdata;
  end

  a_araddr_hold: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    flash_ar.arvalid && !flash_arready |=> flash_ar.arvalid && $stable(flash_ar.araddr));

  a_req_in_idle: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    fetch_req |-> state == S_IDLE);

endmodule

`default_nettype wire

//--- hdl/sample_player.sv
`timescale 1ns/1ps
`default_nettype none
`include "player_config.svh"

module sample_player (
  input  wire logic                        CLK_50M,
  input  wire logic                        rst_n,
  input  wire player_pkg::play_cmd_t       cmd,
  input  wire logic                        tick,
  output logic                             fetch_req,
  output flash_bus_pkg::word_addr_t        fetch_addr,
  input  wire logic                        word_valid,
  input  wire flash_bus_pkg::flash_word_t  word_data,
  output player_pkg::sample_t              sample,
  output logic                             sample_valid
);

  logic                       playing;
  logic                       dir_back;
  logic                       pending;
  logic                       discard;
  logic                       cur_valid;
  logic                       nxt_valid;
  logic                       byte_sel;
  flash_bus_pkg::flash_word_t cur_word;
  flash_bus_pkg::flash_word_t nxt_word;
  flash_bus_pkg::word_addr_t  addr_step;
  logic                       emit;
  logic                       cur_done;
  logic                       cur_take;

  assign emit     = tick && playing && cur_valid;
  assign cur_done = emit && byte_sel;
  // Move the prefetched word into the play slot once it frees
  assign cur_take = nxt_valid && (!cur_valid || cur_done);

  // Prefetch as soon as the next-word slot is free
  assign fetch_req = (playing || cmd.play) && !cmd.stop && !cmd.restart &&
                     !pending && !nxt_valid;

  always_comb
  begin
    if (!dir_back)
      addr_step = (fetch_addr == `SONG_LAST_WORD) ? `SONG_FIRST_WORD : fetch_addr + 1'b1;
    else
      addr_step = (fetch_addr == `SONG_FIRST_WORD) ? `SONG_LAST_WORD : fetch_addr - 1'b1;
  end

  // ====================================================================
  // Play state, address sequencer and buffer flags
  // ====================================================================

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      playing      <= 1'b0;
      dir_back     <= 1'b0;
      fetch_addr   <= `SONG_FIRST_WORD;
      pending      <= 1'b0;
      discard      <= 1'b0;
      cur_valid    <= 1'b0;
      nxt_valid    <= 1'b0;
      byte_sel     <= 1'b0;
      sample_valid <= 1'b0;
    end
    else
    begin
      sample_valid <= emit;

      if (cmd.play)
        playing <= 1'b1;
      else if (cmd.stop)
        playing <= 1'b0;

      if (cmd.forward)
        dir_back <= 1'b0;
      else if (cmd.backward)
        dir_back <= 1'b1;

      if (fetch_req)
        pending <= 1'b1;
      else if (word_valid)
        pending <= 1'b0;

      if (cmd.restart)
      begin
        fetch_addr <= dir_back ? `SONG_LAST_WORD : `SONG_FIRST_WORD;
        // Word still in flight gets dropped on arrival
        discard    <= pending && !word_valid;
        cur_valid  <= 1'b0;
        nxt_valid  <= 1'b0;
        byte_sel   <= 1'b0;
      end
      else
      begin
        if (fetch_req)
          fetch_addr <= addr_step;
        if (word_valid)
          discard <= 1'b0;

        if (word_valid && !discard)
          nxt_valid <= 1'b1;
        else if (cur_take)
          nxt_valid <= 1'b0;

        if (cur_take)
          cur_valid <= 1'b1;
        else if (cur_done)
          cur_valid <= 1'b0;

        if (emit)
          byte_sel <= ~byte_sel;
      end
    end
  end

  // Word and sample registers
  always_ff @(posedge CLK_50M)
  begin
    if (word_valid && !discard)
      nxt_word <= word_data;
    if (cur_take)
      cur_word <= nxt_word;
    if (emit)
      sample <= (byte_sel ^ dir_back) ? cur_word[31:24] : cur_word[15:8];
  end

  a_one_fetch: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    fetch_req |=> !fetch_req until word_valid);

endmodule

`default_nettype wire

//--- hdl/hex_display.sv
`timescale 1ns/1ps
`default_nettype none

module hex_display (
  input  wire logic                  CLK_50M,
  input  wire logic                  rst_n,
  input  wire player_pkg::divider_t  divider,
  output player_pkg::hex_digits_t    hex
);

  logic [23:0]             digits;
  player_pkg::hex_digits_t hex_next;

  assign digits = {8'h00, divider};

  // Segment order gfedcba where low means lit
  function automatic player_pkg::seg_t seg_of(input logic [3:0] nibble);
    case (nibble)
      4'h0:    return 7'b1000000;
      4'h1:    return 7'b1111001;
      4'h2:    return 7'b0100100;
      4'h3:    return 7'b0110000;
      4'h4:    return 7'b0011001;
      4'h5:    return 7'b0010010;
      4'h6:    return 7'b0000010;
      4'h7:    return 7'b1111000;
      4'h8:    return 7'b0000000;
      4'h9:    return 7'b0010000;
      4'hA:    return 7'b0001000;
      4'hB:    return 7'b0000011;
      4'hC:    return 7'b1000110;
      4'hD:    return 7'b0100001;
      4'hE:    return 7'b0000110;
      default: return 7'b0001110;
    endcase
  endfunction

  always_comb
  begin
    for (int i = 0; i < 6; i++)
    begin
      hex_next[i] = seg_of(digits[4*i +: 4]);
    end
  end

  // Blank until the first update after reset
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
      hex <= '1;
    else
      hex <= hex_next;
  end

endmodule

`default_nettype wire

//--- hdl/ipod_top.sv
`timescale 1ns/1ps
`default_nettype none

module ipod_top (
  input  wire logic                     CLK_50M,
  input  wire logic                     rst_n,
  input  wire logic                     key_valid,
  input  wire logic [7:0]               key_ascii,
  input  wire logic                     speed_up,
  input  wire logic                     speed_down,
  input  wire logic                     speed_reset,
  output flash_bus_pkg::axil_ar_t       flash_ar,
  input  wire logic                     flash_arready,
  input  wire flash_bus_pkg::axil_r_t   flash_r,
  output logic                          flash_rready,
  output player_pkg::sample_t           sample,
  output logic                          sample_valid,
  output player_pkg::hex_digits_t       hex
);

  player_pkg::play_cmd_t      cmd;
  player_pkg::divider_t       divider;
  logic                       tick;
  logic                       fetch_req;
  flash_bus_pkg::word_addr_t  fetch_addr;
  logic                       word_valid;
  flash_bus_pkg::flash_word_t word_data;

  // ====================================================================
  // Control path
  // ====================================================================

  command_decoder u_command_decoder (
    .CLK_50M   (CLK_50M),
    .rst_n     (rst_n),
    .key_valid (key_valid),
    .key_ascii (key_ascii),
    .cmd       (cmd)
  );

  rate_control u_rate_control (
    .CLK_50M     (CLK_50M),
    .rst_n       (rst_n),
    .speed_up    (speed_up),
    .speed_down  (speed_down),
    .speed_reset (speed_reset),
    .divider     (divider),
    .tick        (tick)
  );

  hex_display u_hex_display (
    .CLK_50M (CLK_50M),
    .rst_n   (rst_n),
    .divider (divider),
    .hex     (hex)
  );

  // ====================================================================
  // Sample path from flash
  // ====================================================================

  sample_player u_sample_player (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .cmd          (cmd),
    .tick         (tick),
    .fetch_req    (fetch_req),
    .fetch_addr   (fetch_addr),
    .word_valid   (word_valid),
    .word_data    (word_data),
    .sample       (sample),
    .sample_valid (sample_valid)
  );

  flash_reader u_flash_reader (
    .CLK_50M       (CLK_50M),
    .rst_n         (rst_n),
    .fetch_req     (fetch_req),
    .fetch_addr    (fetch_addr),
    .word_valid    (word_valid),
    .word_data     (word_data),
    .flash_ar      (flash_ar),
    .flash_arready (flash_arready),
    .flash_r       (flash_r),
    .flash_rready  (flash_rready)
  );

endmodule

`default_nettype wire

//--- bench/tb_ipod.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ipod;

  logic                       CLK_50M;
  logic                       rst_n;
  logic                       key_valid;
  logic [7:0]                 key_ascii;
  logic                       speed_up;
  logic                       speed_down;
  logic                       speed_reset;
  flash_bus_pkg::axil_ar_t    flash_ar;
  logic                       flash_arready;
  flash_bus_pkg::axil_r_t     flash_r;
  logic                       flash_rready;
  player_pkg::sample_t        sample;
  logic                       sample_valid;
  player_pkg::hex_digits_t    hex;

  logic [31:0] mem [logic [22:0]];
  logic [31:0] xor_const;
  logic [7:0]  sample_q[$];
  logic [24:0] araddr_q[$];
  int          seed;

  ipod_top uut (
    .CLK_50M       (CLK_50M),
    .rst_n         (rst_n),
    .key_valid     (key_valid),
    .key_ascii     (key_ascii),
    .speed_up      (speed_up),
    .speed_down    (speed_down),
    .speed_reset   (speed_reset),
    .flash_ar      (flash_ar),
    .flash_arready (flash_arready),
    .flash_r       (flash_r),
    .flash_rready  (flash_rready),
    .sample        (sample),
    .sample_valid  (sample_valid),
    .hex           (hex)
  );

  always #10 CLK_50M = ~CLK_50M;

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
      stop_on_error($sformatf("Fail %s: got %h, expected %h", name, got, exp));
  endtask

  // Standard active-low patterns in gfedcba order
  function automatic logic [6:0] digit_pattern(input logic [3:0] n);
    case (n)
      4'h0: return 7'h40;
      4'h1: return 7'h79;
      4'h2: return 7'h24;
      4'h3: return 7'h30;
      4'h4: return 7'h19;
      4'h5: return 7'h12;
      4'h6: return 7'h02;
      4'h7: return 7'h78;
      4'h8: return 7'h00;
      4'h9: return 7'h10;
      4'hA: return 7'h08;
      4'hB: return 7'h03;
      4'hC: return 7'h46;
      4'hD: return 7'h21;
      4'hE: return 7'h06;
      default: return 7'h0E;
    endcase
  endfunction

  function automatic logic [41:0] segments_for(input logic [15:0] div);
    logic [23:0] d;
    logic [41:0] r;
    d = {8'h00, div};
    for (int i = 0; i < 6; i++)
      r[7*i +: 7] = digit_pattern(d[4*i +: 4]);
    return r;
  endfunction

  task automatic next_cycle();
    @(posedge CLK_50M);
    #2;
  endtask

  task automatic send_key(input logic [7:0] code);
    key_valid = 1'b1;
    key_ascii = code;
    next_cycle();
    key_valid = 1'b0;
  endtask

  task automatic press(input string kind, input int count);
    for (int i = 0; i < count; i++)
    begin
      if (kind == "u") speed_up = 1'b1;
      else if (kind == "d") speed_down = 1'b1;
      else speed_reset = 1'b1;
      repeat (2) next_cycle();
      speed_up    = 1'b0;
      speed_down  = 1'b0;
      speed_reset = 1'b0;
      repeat (2) next_cycle();
    end
  endtask

  // ==================================================================
  // Flash model with random ready and valid delays
  // ==================================================================

  initial
  begin
    logic [24:0] addr;
    logic [22:0] waddr;
    forever
    begin
      next_cycle();
      if (rst_n && flash_ar.arvalid)
      begin
        repeat ($urandom % 4) next_cycle();
        flash_arready = 1'b1;
        addr = flash_ar.araddr;
        araddr_q.push_back(addr);
        next_cycle();
        flash_arready = 1'b0;
        waddr = addr[24:2];
        repeat ($urandom % 4) next_cycle();
        // rready must stay up from the address handshake on
        check("flash_rready", flash_rready, 1'b1);
        flash_r.rvalid = 1'b1;
        flash_r.rdata  = mem.exists(waddr) ? mem[waddr] : {9'd0, waddr} ^ xor_const;
        next_cycle();
        flash_r.rvalid = 1'b0;
        check("flash_rready", flash_rready, 1'b0);
      end
    end
  end

  // Outputs are stable at the falling edge
  always @(negedge CLK_50M)
  begin
    if (rst_n && sample_valid)
      sample_q.push_back(sample);
  end

  initial
  begin
    int          fd;
    int          n;
    int          code;
    string       line;
    string       op;
    string       kind;
    logic [31:0] v1;
    logic [31:0] v2;
    CLK_50M = 1'b0;
    rst_n = 1'b0;
    key_valid = 1'b0;
    key_ascii = 8'h00;
    speed_up = 1'b0;
    speed_down = 1'b0;
    speed_reset = 1'b0;
    flash_arready = 1'b0;
    flash_r = '0;
    xor_const = '0;
    seed = 25;
    void'($urandom(seed));
    fd = $fopen("bench/ipod_stim.txt", "r");
    if (fd == 0)
      stop_on_error("Could not open the stimulus file bench/ipod_stim.txt");
    repeat (8) @(posedge CLK_50M);
    #2 rst_n = 1'b1;
    while (!$feof(fd))
    begin
      line = "";
      code = $fgets(line, fd);
      op = "";
      code = $sscanf(line, "%s", op);
      if (op == "x")
        code = $sscanf(line, "%s %h", op, xor_const);
      else if (op == "m")
      begin
        code = $sscanf(line, "%s %h %h", op, v1, v2);
        mem[v1[22:0]] = v2;
      end
      else if (op == "k")
      begin
        code = $sscanf(line, "%s %h", op, v1);
        send_key(v1[7:0]);
      end
      else if (op == "b")
      begin
        code = $sscanf(line, "%s %s %d", op, kind, n);
        press(kind, n);
      end
      else if (op == "w")
      begin
        code = $sscanf(line, "%s %d", op, n);
        repeat (n) next_cycle();
      end
      else if (op == "c")
      begin
        sample_q.delete();
        araddr_q.delete();
      end
      else if (op == "n")
      begin
        code = $sscanf(line, "%s %d", op, n);
        repeat (n) next_cycle();
        check("sample_valid count", sample_q.size(), 0);
        check("arvalid count", araddr_q.size(), 0);
      end
      else if (op == "s")
      begin
        code = $sscanf(line, "%s %h", op, v1);
        for (n = 0; n < 20000 && sample_q.size() == 0; n++)
          next_cycle();
        if (sample_q.size() == 0)
          stop_on_error("Timed out waiting for sample_valid");
        check("sample", sample_q.pop_front(), v1[7:0]);
      end
      else if (op == "a")
      begin
        code = $sscanf(line, "%s %h", op, v1);
        for (n = 0; n < 20000 && araddr_q.size() == 0; n++)
          next_cycle();
        if (araddr_q.size() == 0)
          stop_on_error("Timed out waiting for a read address handshake");
        check("araddr", araddr_q.pop_front(), v1[24:0]);
      end
      else if (op == "h")
      begin
        code = $sscanf(line, "%s %h", op, v1);
        for (n = 0; n < 10 && hex !== segments_for(v1[15:0]); n++)
          next_cycle();
        check("hex", hex, segments_for(v1[15:0]));
      end
    end
    $fclose(fd);
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/ipod_stim.txt
# x xorconst | m waddr data | k ascii | b u/d/r count | w cycles | c clear
# n cycles quiet | s sample | a araddr | h divider shown
x 12345678
m 00000 11AA22BB
m 00001 33CC44DD
m 00002 55EE66FF
m 00003 77018802
m 7FFFF 9A10BC20
m 7FFFE DE30F040
h 0D90
n 200
k 45
a 0
a 4
a 8
s 22
s 11
s 44
s 33
s 66
s 55
k 44
w 20
c
n 20000
k 45
s 88
s 77
s 56
s 12
k 44
w 20
c
k 42
k 52
k 45
a 1FFFFC
a 1FFFF8
s 9A
s BC
s DE
s F0
s 12
s A9
a 1FFFF4
k 44
w 20
c
k 46
k 52
k 65
a 0
a 4
s 22
s 11
s 44
b d 2
b u 1
h 0DF4
b r 1
h 0D90
b u 60
h 03E8

//--- tb.f
+incdir+hdl
hdl/player_pkg.sv
hdl/flash_bus_pkg.sv
hdl/command_decoder.sv
hdl/rate_control.sv
hdl/flash_reader.sv
hdl/sample_player.sv
hdl/hex_display.sv
hdl/ipod_top.sv
bench/tb_ipod.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_ipod
FILELIST  = tb.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@! grep -q "Simulation finished: FAIL" $(LOG)
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
